/* common/ps2_pkg.sv */
package ps2_pkg;

	// set 2 scan codes for the navigation keys and the prefix bytes
	typedef enum logic [7:0] {
		KEY_Q        = 8'h15,
		KEY_S        = 8'h1B,
		KEY_A        = 8'h1C,
		KEY_W        = 8'h1D,
		KEY_D        = 8'h23,
		KEY_E        = 8'h24,
		EXT_PREFIX   = 8'hE0,
		BREAK_PREFIX = 8'hF0
	} scan_code_e;

	// bit position of each key in the held-key mask
	typedef enum int unsigned {
		IDX_W = 0,
		IDX_A = 1,
		IDX_S = 2,
		IDX_D = 3,
		IDX_Q = 4,
		IDX_E = 5
	} key_idx_e;

	// width of the held-key mask
	localparam int NUM_KEYS = 6;

	// start, 8 data bits, odd parity, stop
	localparam int FRAME_BITS = 11;

endpackage

/* common/camera_pkg.sv */
package camera_pkg;

	// eye coordinates are signed integers, wrap in two's complement
	localparam int COORD_W = 16;

	// eye position after reset
	localparam logic signed [COORD_W-1:0] EYE_X0 = 16'sd3;
	localparam logic signed [COORD_W-1:0] EYE_Y0 = 16'sd3;
	localparam logic signed [COORD_W-1:0] EYE_Z0 = -16'sd15;

	// frame sequencing states
	typedef enum logic {
		CAM_IDLE   = 1'b0,
		CAM_RENDER = 1'b1
	} cam_state_e;

endpackage

/* ps2/ps2_rx.sv */
`timescale 1ns/10ps

module ps2_rx (
	input  logic       pkt_rec,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] rx_byte,
	output logic       byte_valid,
	output logic       frame_err
);

	import ps2_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BITS);

	// two-flop synchronizers, both lines idle high
	logic clk_meta, clk_sync, clk_prev;
	logic data_meta, data_sync;

	logic                  clk_fall;
	logic [CNT_W-1:0]      bit_cnt;
	logic                  last_bit;
	logic [FRAME_BITS-1:0] shift_reg;
	logic [FRAME_BITS-1:0] frame_next;
	logic                  start_ok, stop_ok, parity_ok;
	logic                  frame_ok;

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			clk_prev  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk;
			clk_sync  <= clk_meta;
			clk_prev  <= clk_sync;
			data_meta <= ps2_data;
			data_sync <= data_meta;
		end
	end

	assign clk_fall = clk_prev & ~clk_sync;
	assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

	// bits arrive lsb first, so shift in from the top
	assign frame_next = {data_sync, shift_reg[FRAME_BITS-1:1]};

	assign start_ok  = ~frame_next[0];
	assign stop_ok   = frame_next[FRAME_BITS-1];
	// odd parity over data plus parity bit
	assign parity_ok = ^frame_next[FRAME_BITS-2:1];
	assign frame_ok  = start_ok & stop_ok & parity_ok;

	always_ff @(posedge pkt_rec) begin
		if (clk_fall) begin
			shift_reg <= frame_next;
			if (last_bit)
				rx_byte <= frame_next[8:1];
		end
	end

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
			if (clk_fall) begin
				if (last_bit) begin
					bit_cnt    <= '0;
					byte_valid <= frame_ok;
					frame_err  <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// the device changes data only while ps2_clk is high
	a_data_stable_at_fall: assert property (
		@(posedge pkt_rec) disable iff (rst)
		clk_fall |-> $stable(data_sync)
	) else $error("ps2_data changed at a falling edge of ps2_clk");

endmodule

/* ps2/key_decoder.sv */
`timescale 1ns/10ps

module key_decoder (
	input  logic                          pkt_rec,
	input  logic                          rst,
	input  logic [7:0]                    rx_byte,
	input  logic                          byte_valid,
	output logic [ps2_pkg::NUM_KEYS-1:0]  key_mask
);

	import ps2_pkg::*;

	logic                break_pending;
	logic [NUM_KEYS-1:0] hit;

	// one-hot key for the current byte, zero for anything else
	always_comb begin
		hit = '0;
		case (rx_byte)
			KEY_W:   hit[IDX_W] = 1'b1;
			KEY_A:   hit[IDX_A] = 1'b1;
			KEY_S:   hit[IDX_S] = 1'b1;
			KEY_D:   hit[IDX_D] = 1'b1;
			KEY_Q:   hit[IDX_Q] = 1'b1;
			KEY_E:   hit[IDX_E] = 1'b1;
			default: hit = '0;
		endcase
	end

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			key_mask      <= '0;
			break_pending <= 1'b0;
		end else if (byte_valid) begin
			case (rx_byte)
				BREAK_PREFIX: break_pending <= 1'b1;
				// extended codes are not decoded, flag is kept
				EXT_PREFIX: break_pending <= break_pending;
				default: begin
					break_pending <= 1'b0;
					if (break_pending)
						key_mask <= key_mask & ~hit;
					else
						key_mask <= key_mask | hit;
				end
			endcase
		end
	end

endmodule

/* rtl/camera_controller.sv */
`timescale 1ns/10ps

module camera_controller #(
	parameter int MOVE_STEP = 1
) (
	input  logic                                 pkt_rec,
	input  logic                                 rst,
	input  logic                                 run,
	input  logic [ps2_pkg::NUM_KEYS-1:0]         key_mask,
	input  logic                                 rendering_done,
	output logic                                 render_frame,
	output logic                                 busy,
	output logic signed [camera_pkg::COORD_W-1:0] eye_x,
	output logic signed [camera_pkg::COORD_W-1:0] eye_y,
	output logic signed [camera_pkg::COORD_W-1:0] eye_z
);

	import ps2_pkg::*;
	import camera_pkg::*;

	localparam logic signed [COORD_W-1:0] STEP = COORD_W'(MOVE_STEP);

	cam_state_e state;

	logic signed [COORD_W-1:0] eye_x_next;
	logic signed [COORD_W-1:0] eye_y_next;
	logic signed [COORD_W-1:0] eye_z_next;

	// one axis, opposite keys cancel
	function automatic logic signed [COORD_W-1:0] axis_move(
		input logic                      inc,
		input logic                      dec,
		input logic signed [COORD_W-1:0] pos
	);
		logic signed [COORD_W-1:0] res;
		case ({inc, dec})
			2'b10:   res = pos + STEP;
			2'b01:   res = pos - STEP;
			default: res = pos;
		endcase
		return res;
	endfunction

	assign eye_x_next = axis_move(key_mask[IDX_D], key_mask[IDX_A], eye_x);
	assign eye_y_next = axis_move(key_mask[IDX_E], key_mask[IDX_Q], eye_y);
	assign eye_z_next = axis_move(key_mask[IDX_W], key_mask[IDX_S], eye_z);

	// strobe in the clock that leaves idle
	assign render_frame = (state == CAM_IDLE) && run;
	assign busy         = (state == CAM_RENDER);

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			state <= CAM_IDLE;
			eye_x <= EYE_X0;
			eye_y <= EYE_Y0;
			eye_z <= EYE_Z0;
		end else begin
			case (state)
				CAM_IDLE: begin
					if (run) begin
						eye_x <= eye_x_next;
						eye_y <= eye_y_next;
						eye_z <= eye_z_next;
						state <= CAM_RENDER;
					end
				end
				CAM_RENDER: begin
					// wait for the tracker to see the whole frame
					if (rendering_done)
						state <= CAM_IDLE;
				end
				default: state <= CAM_IDLE;
			endcase
		end
	end

	// the tracker only finishes a frame that was started
	a_done_while_busy: assert property (
		@(posedge pkt_rec) disable iff (rst)
		rendering_done |-> busy
	) else $error("rendering_done seen while not busy");

endmodule

/* rtl/frame_tracker.sv */
`timescale 1ns/10ps

module frame_tracker #(
	parameter int FRAME_PIXELS = 307200
) (
	input  logic pkt_rec,
	input  logic rst,
	input  logic pix_we,
	output logic rendering_done
);

	localparam int CNT_W = $clog2(FRAME_PIXELS + 1);

	logic [CNT_W-1:0] pix_cnt;
	logic             last_pix;

	assign last_pix = pix_we && (pix_cnt == CNT_W'(FRAME_PIXELS - 1));

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			pix_cnt        <= '0;
			rendering_done <= 1'b0;
		end else begin
			rendering_done <= last_pix;
			if (last_pix)
				pix_cnt <= '0;
			else if (pix_we)
				pix_cnt <= pix_cnt + 1'b1;
		end
	end

endmodule

/* rtl/camera_nav_top.sv */
`timescale 1ns/10ps

module camera_nav_top #(
	parameter int FRAME_PIXELS = 307200,
	parameter int MOVE_STEP    = 1
) (
	input  logic                                 pkt_rec,
	input  logic                                 rst,
	input  logic                                 ps2_clk,
	input  logic                                 ps2_data,
	input  logic                                 run,
	input  logic                                 pix_we,
	output logic                                 frame_err,
	output logic [ps2_pkg::NUM_KEYS-1:0]         key_mask,
	output logic                                 render_frame,
	output logic                                 busy,
	output logic signed [camera_pkg::COORD_W-1:0] eye_x,
	output logic signed [camera_pkg::COORD_W-1:0] eye_y,
	output logic signed [camera_pkg::COORD_W-1:0] eye_z,
	output logic                                 rendering_done
);

	// receiver to decoder
	logic [7:0] rx_byte;
	logic       byte_valid;

	ps2_rx u_ps2_rx (
		.pkt_rec    (pkt_rec),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.frame_err  (frame_err)
	);

	key_decoder u_key_decoder (
		.pkt_rec    (pkt_rec),
		.rst        (rst),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.key_mask   (key_mask)
	);

	camera_controller #(
		.MOVE_STEP (MOVE_STEP)
	) u_camera_controller (
		.pkt_rec        (pkt_rec),
		.rst            (rst),
		.run            (run),
		.key_mask       (key_mask),
		.rendering_done (rendering_done),
		.render_frame   (render_frame),
		.busy           (busy),
		.eye_x          (eye_x),
		.eye_y          (eye_y),
		.eye_z          (eye_z)
	);

	frame_tracker #(
		.FRAME_PIXELS (FRAME_PIXELS)
	) u_frame_tracker (
		.pkt_rec        (pkt_rec),
		.rst            (rst),
		.pix_we         (pix_we),
		.rendering_done (rendering_done)
	);

endmodule

/* tests/tb_camera_nav.sv */
`timescale 1ns/10ps

module tb_camera_nav;

	import ps2_pkg::*;
	import camera_pkg::*;

	localparam int STEP = 4;
	localparam int PIXELS = 16;

	logic                      pkt_rec;
	logic                      rst;
	logic                      ps2_clk;
	logic                      ps2_data;
	logic                      run;
	logic                      pix_we;
	logic                      frame_err;
	logic [NUM_KEYS-1:0]       key_mask;
	logic                      render_frame;
	logic                      busy;
	logic signed [COORD_W-1:0] eye_x;
	logic signed [COORD_W-1:0] eye_y;
	logic signed [COORD_W-1:0] eye_z;
	logic                      rendering_done;

	// reference model of held keys and eye
	logic [NUM_KEYS-1:0]       model_mask;
	logic                      model_break;
	logic signed [COORD_W-1:0] model_x;
	logic signed [COORD_W-1:0] model_y;
	logic signed [COORD_W-1:0] model_z;
	logic [31:0]               lcg_state;

	camera_nav_top #(
		.FRAME_PIXELS (PIXELS),
		.MOVE_STEP    (STEP)
	) dut0 (
		.pkt_rec        (pkt_rec),
		.rst            (rst),
		.ps2_clk        (ps2_clk),
		.ps2_data       (ps2_data),
		.run            (run),
		.pix_we         (pix_we),
		.frame_err      (frame_err),
		.key_mask       (key_mask),
		.render_frame   (render_frame),
		.busy           (busy),
		.eye_x          (eye_x),
		.eye_y          (eye_y),
		.eye_z          (eye_z),
		.rendering_done (rendering_done)
	);

	initial begin
		pkt_rec = 1'b0;
		forever #2 pkt_rec = ~pkt_rec;
	end

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		$display("[ERROR] %s expected %h actual %h", name, exp, act);
		stop_on_failure();
	endtask

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// no new frame may start while one is in flight
	a_no_start_while_busy: assert property (
		@(posedge pkt_rec) disable iff (rst)
		!(render_frame && busy)
	) else begin
		$display("render_frame was raised while busy was high");
		stop_on_failure();
	end

	a_done_single_pulse: assert property (
		@(posedge pkt_rec) disable iff (rst)
		rendering_done |=> (!rendering_done && !busy)
	) else begin
		$display("rendering_done was not a single pulse followed by busy low");
		stop_on_failure();
	end

	function automatic logic [1:0] lcg_gap();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[17:16];
	endfunction

	task automatic apply_code(input logic [7:0] code);
		int idx;
		idx = -1;
		case (code)
			KEY_W: idx = IDX_W;
			KEY_A: idx = IDX_A;
			KEY_S: idx = IDX_S;
			KEY_D: idx = IDX_D;
			KEY_Q: idx = IDX_Q;
			KEY_E: idx = IDX_E;
			default: idx = -1;
		endcase
		if (code == BREAK_PREFIX) begin
			model_break = 1'b1;
		end else if (code != EXT_PREFIX) begin
			if (idx >= 0)
				model_mask[idx] = !model_break;
			model_break = 1'b0;
		end
	endtask

	// keyboard side, 20 system clocks per bit, leaves ps2_clk low after bit 10
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge pkt_rec) ps2_data <= bits[i];
			repeat (9) @(posedge pkt_rec);
			ps2_clk <= 1'b0;
			if (i < 10) begin
				repeat (10) @(posedge pkt_rec);
				ps2_clk <= 1'b1;
			end
		end
	endtask

	task automatic send_and_check(input logic [7:0] data, input logic bad_parity);
		logic [NUM_KEYS-1:0] old_mask;
		old_mask = model_mask;
		if (!bad_parity)
			apply_code(data);
		send_frame(data, bad_parity);
		// mask moves 4 cycles after the last falling edge
		for (int k = 0; k <= 4; k++) begin
			@(negedge pkt_rec);
			check_value("key_mask", (k == 4) ? model_mask : old_mask, key_mask);
			check_value("frame_err", (k == 3) ? bad_parity : 1'b0, frame_err);
		end
		repeat (6) @(posedge pkt_rec);
		ps2_clk  <= 1'b1;
		ps2_data <= 1'b1;
		repeat (10) @(posedge pkt_rec);
	endtask

	task automatic run_frame();
		int n;
		logic [1:0] gap;
		@(posedge pkt_rec) run <= 1'b1;
		n = 0;
		@(negedge pkt_rec);
		while (!render_frame) begin
			if (n == 20) begin
				$display("timed out waiting for render_frame");
				stop_on_failure();
			end
			n++;
			@(negedge pkt_rec);
		end
		if (model_mask[IDX_D] && !model_mask[IDX_A]) model_x = model_x + STEP;
		if (model_mask[IDX_A] && !model_mask[IDX_D]) model_x = model_x - STEP;
		if (model_mask[IDX_E] && !model_mask[IDX_Q]) model_y = model_y + STEP;
		if (model_mask[IDX_Q] && !model_mask[IDX_E]) model_y = model_y - STEP;
		if (model_mask[IDX_W] && !model_mask[IDX_S]) model_z = model_z + STEP;
		if (model_mask[IDX_S] && !model_mask[IDX_W]) model_z = model_z - STEP;
		// run stays high for the whole frame, so a start during busy would show
		@(negedge pkt_rec);
		check_value("busy", 1'b1, busy);
		check_value("eye_x", model_x, eye_x);
		check_value("eye_y", model_y, eye_y);
		check_value("eye_z", model_z, eye_z);
		// renderer writes with random gaps
		for (int i = 0; i < PIXELS; i++) begin
			@(posedge pkt_rec) pix_we <= 1'b1;
			if (i < PIXELS - 1) begin
				gap = lcg_gap();
				if (gap != 0) begin
					@(posedge pkt_rec) pix_we <= 1'b0;
					repeat (gap - 1) @(posedge pkt_rec);
				end
			end
		end
		@(posedge pkt_rec) pix_we <= 1'b0;
		@(negedge pkt_rec);
		check_value("rendering_done", 1'b1, rendering_done);
		check_value("busy", 1'b1, busy);
		@(posedge pkt_rec) run <= 1'b0;
		@(negedge pkt_rec);
		check_value("rendering_done", 1'b0, rendering_done);
		check_value("busy", 1'b0, busy);
	endtask

	initial begin
		rst         = 1'b1;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		run         = 1'b0;
		pix_we      = 1'b0;
		lcg_state   = 32'd53;
		model_mask  = '0;
		model_break = 1'b0;
		model_x     = EYE_X0;
		model_y     = EYE_Y0;
		model_z     = EYE_Z0;
		repeat (5) @(posedge pkt_rec);
		rst <= 1'b0;
		@(negedge pkt_rec);
		check_value("render_frame", 1'b0, render_frame);
		check_value("busy", 1'b0, busy);
		check_value("rendering_done", 1'b0, rendering_done);
		check_value("frame_err", 1'b0, frame_err);
		check_value("key_mask", '0, key_mask);
		check_value("eye_x", EYE_X0, eye_x);
		check_value("eye_y", EYE_Y0, eye_y);
		check_value("eye_z", EYE_Z0, eye_z);

		// make codes, then an ignored extended prefix
		send_and_check(KEY_W, 1'b0);
		send_and_check(KEY_D, 1'b0);
		send_and_check(EXT_PREFIX, 1'b0);
		run_frame();

		// release W only
		send_and_check(BREAK_PREFIX, 1'b0);
		send_and_check(KEY_W, 1'b0);
		run_frame();

		// corrupted frame is dropped, the retry decodes
		send_and_check(KEY_Q, 1'b1);
		send_and_check(KEY_Q, 1'b0);

		// A against D cancels on x
		send_and_check(KEY_A, 1'b0);
		run_frame();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* tb.f */
common/ps2_pkg.sv
common/camera_pkg.sv
ps2/ps2_rx.sv
ps2/key_decoder.sv
rtl/camera_controller.sv
rtl/frame_tracker.sv
rtl/camera_nav_top.sv
tests/tb_camera_nav.sv
